/* filelist.f */
logic/mem_cfg_pkg.sv
logic/mem_bus_pkg.sv
logic/memory.sv
logic/mem_arbiter.sv
logic/mem_subsystem.sv
testbench/mem_subsystem_sva.sv
testbench/mem_subsystem_tb.sv

/* logic/mem_arbiter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-port round-robin arbiter for the shared RAM
// Runs a four-phase req/ack handshake per port, one RAM access per
// request, returns the RAM output with the ack
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mem_arbiter (
    input  logic                  clk,
    input  logic                  i_rst,

    // Requester ports
    input  logic                  i_req_a,
    input  logic                  i_req_b,
    input  mem_bus_pkg::mem_req_t i_cmd_a,
    input  mem_bus_pkg::mem_req_t i_cmd_b,
    output logic                  o_ack_a,
    output logic                  o_ack_b,
    output mem_cfg_pkg::word_t    o_rdata_a,
    output mem_cfg_pkg::word_t    o_rdata_b,

    // RAM side
    output mem_cfg_pkg::addr_t    o_mem_addr,
    output mem_cfg_pkg::word_t    o_mem_din,
    output logic                  o_mem_wen,
    output logic                  o_mem_ren,
    input  mem_cfg_pkg::word_t    i_mem_dout
);

    mem_bus_pkg::arb_state_t state;
    mem_bus_pkg::port_sel_t  grant;       // Port being served
    mem_bus_pkg::port_sel_t  last_srv;    // Port served most recently

    mem_bus_pkg::port_sel_t  pick;        // Winner if sampled in idle
    mem_bus_pkg::mem_req_t   pick_cmd;    // Winner's command
    logic                    any_req;
    logic                    gnt_req;     // Req of the granted port
    logic                    gnt_ack;     // Ack of the granted port

    assign any_req = i_req_a | i_req_b;

    // Round-robin pick, both high gives the port not served last
    always_comb begin
        if (i_req_a && i_req_b) begin
            pick = (last_srv == mem_bus_pkg::PORT_A) ? mem_bus_pkg::PORT_B
                                                     : mem_bus_pkg::PORT_A;
        end else if (i_req_a) begin
            pick = mem_bus_pkg::PORT_A;
        end else begin
            pick = mem_bus_pkg::PORT_B;
        end
    end

    assign pick_cmd = (pick == mem_bus_pkg::PORT_A) ? i_cmd_a : i_cmd_b;

    assign gnt_req = (grant == mem_bus_pkg::PORT_A) ? i_req_a : i_req_b;
    assign gnt_ack = (grant == mem_bus_pkg::PORT_A) ? o_ack_a : o_ack_b;

    // Control FSM
    always_ff @(posedge clk) begin
        if (i_rst) begin
            state     <= mem_bus_pkg::ST_IDLE;
            grant     <= mem_bus_pkg::PORT_A;
            last_srv  <= mem_bus_pkg::PORT_B;    // Port A wins first contention
            o_ack_a   <= 1'b0;
            o_ack_b   <= 1'b0;
            o_mem_wen <= 1'b0;
            o_mem_ren <= 1'b0;
        end else begin
            case (state)
                mem_bus_pkg::ST_IDLE: begin
                    if (any_req) begin
                        grant     <= pick;
                        last_srv  <= pick;
                        o_mem_wen <= pick_cmd.write;
                        o_mem_ren <= 1'b1;    // Also on writes, stored word returns
                        state     <= mem_bus_pkg::ST_ACCESS;
                    end
                end

                mem_bus_pkg::ST_ACCESS: begin
                    // Enables were high for this one cycle only
                    o_mem_wen <= 1'b0;
                    o_mem_ren <= 1'b0;
                    state     <= mem_bus_pkg::ST_RESP;
                end

                mem_bus_pkg::ST_RESP: begin
                    if (!gnt_ack) begin
                        // RAM output now valid, ack the granted port
                        o_ack_a <= (grant == mem_bus_pkg::PORT_A);
                        o_ack_b <= (grant == mem_bus_pkg::PORT_B);
                    end else if (!gnt_req) begin
                        // Requester done, drop ack
                        o_ack_a <= 1'b0;
                        o_ack_b <= 1'b0;
                        state   <= mem_bus_pkg::ST_RELEASE;
                    end
                    // Req still high holds ack, other port waits
                end

                mem_bus_pkg::ST_RELEASE: begin
                    state <= mem_bus_pkg::ST_IDLE;
                end

                default: begin
                    state <= mem_bus_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // Address and write data, loaded with the grant
    always_ff @(posedge clk) begin
        if (state == mem_bus_pkg::ST_IDLE && any_req) begin
            o_mem_addr <= pick_cmd.addr;
            o_mem_din  <= pick_cmd.wdata;
        end
    end

    // RAM output holds until the next access, valid on the acked port
    assign o_rdata_a = i_mem_dout;
    assign o_rdata_b = i_mem_dout;

endmodule

/* logic/mem_bus_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory bus package
// Requester command struct, grant port select and arbiter FSM states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mem_bus_pkg;

    // Command held by a requester from req rise until ack falls
    typedef struct packed {
        mem_cfg_pkg::addr_t addr;     // Target word
        mem_cfg_pkg::word_t wdata;    // Store data, ignored on a read
        logic               write;    // 1 = write, 0 = read
    } mem_req_t;

    // Port holding or last holding the grant
    typedef enum logic {
        PORT_A = 1'b0,
        PORT_B = 1'b1
    } port_sel_t;

    // Arbiter handshake FSM
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,    // Waiting for a req
        ST_ACCESS  = 2'd1,    // RAM enables high
        ST_RESP    = 2'd2,    // Ack high until req drops
        ST_RELEASE = 2'd3     // Ack low, one cycle before idle
    } arb_state_t;

endpackage

/* logic/mem_cfg_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory configuration package
// Word and address widths of the shared RAM, and the depth that
// follows from the address width
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mem_cfg_pkg;

    localparam int WORD_W = 32;    // Bits per memory word
    localparam int ADDR_W = 10;    // Word address bits

    // One memory word
    typedef logic [WORD_W-1:0] word_t;

    // Word address, no byte offset
    typedef logic [ADDR_W-1:0] addr_t;

    // Every address value maps to one word
    localparam int MEM_DEPTH = 1 << ADDR_W;

endpackage

/* logic/mem_subsystem.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared memory subsystem top
// Two four-phase requester ports arbitrated onto one RAM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mem_subsystem (
    input  logic                  clk,
    input  logic                  i_rst,

    // Port A
    input  logic                  i_req_a,
    input  mem_bus_pkg::mem_req_t i_cmd_a,
    output logic                  o_ack_a,
    output mem_cfg_pkg::word_t    o_rdata_a,

    // Port B
    input  logic                  i_req_b,
    input  mem_bus_pkg::mem_req_t i_cmd_b,
    output logic                  o_ack_b,
    output mem_cfg_pkg::word_t    o_rdata_b
);

    // Arbiter to RAM
    mem_cfg_pkg::addr_t mem_addr;
    mem_cfg_pkg::word_t mem_din;
    mem_cfg_pkg::word_t mem_dout;
    logic               mem_wen;
    logic               mem_ren;

    mem_arbiter u_arbiter (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_req_a    (i_req_a),
        .i_req_b    (i_req_b),
        .i_cmd_a    (i_cmd_a),
        .i_cmd_b    (i_cmd_b),
        .o_ack_a    (o_ack_a),
        .o_ack_b    (o_ack_b),
        .o_rdata_a  (o_rdata_a),
        .o_rdata_b  (o_rdata_b),
        .o_mem_addr (mem_addr),
        .o_mem_din  (mem_din),
        .o_mem_wen  (mem_wen),
        .o_mem_ren  (mem_ren),
        .i_mem_dout (mem_dout)
    );

    memory u_memory (
        .clk    (clk),
        .i_rst  (i_rst),
        .i_din  (mem_din),
        .i_addr (mem_addr),
        .i_wen  (mem_wen),
        .i_ren  (mem_ren),
        .o_dout (mem_dout)
    );

endmodule

/* logic/memory.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-port synchronous RAM, MEM_DEPTH words
// Reset clears every word and the output register, a write with
// read enabled returns the stored word on o_dout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module memory (
    input  logic               clk,
    input  logic               i_rst,
    input  mem_cfg_pkg::word_t i_din,     // Write data
    input  mem_cfg_pkg::addr_t i_addr,    // Word address
    input  logic               i_wen,     // Write enable
    input  logic               i_ren,     // Read enable
    output mem_cfg_pkg::word_t o_dout     // Registered read data
);

    // Storage array
    mem_cfg_pkg::word_t ram_array [mem_cfg_pkg::MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (i_rst) begin
            // Clear the whole array in the reset cycle
            for (int i = 0; i < mem_cfg_pkg::MEM_DEPTH; i++) begin
                ram_array[i] <= '0;
            end
            o_dout <= '0;
        end else begin
            if (i_wen) begin
                ram_array[i_addr] <= i_din;    // Store
            end

            if (i_wen && i_ren) begin
                o_dout <= i_din;               // Write-through, new word out
            end else if (i_ren) begin
                o_dout <= ram_array[i_addr];   // Plain read
            end
            // No enable, o_dout keeps the last access result
        end
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator.
# Exit status 0 only when the simulation output holds the pass line.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

TOP=mem_subsystem_tb
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
    -f filelist.f \
    --top-module "$TOP" \
    -Mdir "$OBJ" \
    -o "$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

OUTPUT="$("./$OBJ/$TOP")"
STATUS=$?
echo "$OUTPUT"

if [ $STATUS -ne 0 ]; then
    echo "simulation exited with status $STATUS"
    exit 1
fi

if grep -qx ">>> PASS" <<< "$OUTPUT"; then
    exit 0
else
    echo "pass line not found in simulation output"
    exit 1
fi

/* testbench/mem_subsystem_sva.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Handshake assertions for the shared memory subsystem
// Ack exclusivity and four-phase ordering on both ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mem_subsystem_sva (
    input logic clk,
    input logic i_rst,
    input logic i_req_a,
    input logic i_req_b,
    input logic i_ack_a,
    input logic i_ack_b
);

    // One grant at a time
    ack_exclusive: assert property (@(posedge clk) disable iff (i_rst)
        !(i_ack_a && i_ack_b))
        else $error("acks of both ports high together");

    // Ack is registered, req was high at the edge that raised it
    ack_a_needs_req: assert property (@(posedge clk) disable iff (i_rst)
        $rose(i_ack_a) |-> $past(i_req_a))
        else $error("port A ack rose without a request");

    ack_b_needs_req: assert property (@(posedge clk) disable iff (i_rst)
        $rose(i_ack_b) |-> $past(i_req_b))
        else $error("port B ack rose without a request");

    // Req low seen with ack high, ack drops at once
    ack_a_release: assert property (@(posedge clk) disable iff (i_rst)
        (i_ack_a && !i_req_a) |=> !i_ack_a)
        else $error("port A ack held after req fell");

    ack_b_release: assert property (@(posedge clk) disable iff (i_rst)
        (i_ack_b && !i_req_b) |=> !i_ack_b)
        else $error("port B ack held after req fell");

    // Control outputs clear in one reset cycle
    ack_reset: assert property (@(posedge clk)
        i_rst |=> (!i_ack_a && !i_ack_b))
        else $error("ack high in the cycle after reset");

endmodule

bind mem_subsystem mem_subsystem_sva u_sva (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_req_a (i_req_a),
    .i_req_b (i_req_b),
    .i_ack_a (o_ack_a),
    .i_ack_b (o_ack_b)
);

/* testbench/mem_subsystem_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the shared memory subsystem
// Directed four-phase tests on both ports, checked against a word
// array model of the RAM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mem_subsystem_tb;

    localparam int ACK_TIMEOUT  = 20;    // Cycles allowed per ack wait
    localparam int RESET_CYCLES = 16;

    logic                  clk = 1'b0;
    logic                  i_rst;
    logic                  i_req_a;
    logic                  i_req_b;
    mem_bus_pkg::mem_req_t i_cmd_a;
    mem_bus_pkg::mem_req_t i_cmd_b;
    logic                  o_ack_a;
    logic                  o_ack_b;
    mem_cfg_pkg::word_t    o_rdata_a;
    mem_cfg_pkg::word_t    o_rdata_b;

    mem_cfg_pkg::word_t ref_mem [mem_cfg_pkg::MEM_DEPTH];    // Expected RAM contents

    integer seed;
    string  test_name;
    int     waited;          // Cycles spent in the last ack wait
    int     last_lat;        // Req rise to ack rise, last access
    int     checks;
    int     errors;
    int     tests_run;
    int     tests_failed;

    mem_subsystem DUT (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_req_a   (i_req_a),
        .i_cmd_a   (i_cmd_a),
        .o_ack_a   (o_ack_a),
        .o_rdata_a (o_rdata_a),
        .i_req_b   (i_req_b),
        .i_cmd_b   (i_cmd_b),
        .o_ack_b   (o_ack_b),
        .o_rdata_b (o_rdata_b)
    );

    always #50 clk = ~clk;    // Period 100

    function automatic mem_bus_pkg::mem_req_t make_cmd(input mem_cfg_pkg::addr_t addr,
                                                       input mem_cfg_pkg::word_t wdata,
                                                       input logic write);
        mem_bus_pkg::mem_req_t cmd;
        cmd.addr  = addr;
        cmd.wdata = wdata;
        cmd.write = write;
        return cmd;
    endfunction

    function automatic logic ack_of(input mem_bus_pkg::port_sel_t port);
        return (port == mem_bus_pkg::PORT_A) ? o_ack_a : o_ack_b;
    endfunction

    function automatic mem_cfg_pkg::word_t rdata_of(input mem_bus_pkg::port_sel_t port);
        return (port == mem_bus_pkg::PORT_A) ? o_rdata_a : o_rdata_b;
    endfunction

    function automatic string port_name(input mem_bus_pkg::port_sel_t port);
        return (port == mem_bus_pkg::PORT_A) ? "A" : "B";
    endfunction

    // Caller is on a falling edge
    task automatic raise_req(input mem_bus_pkg::port_sel_t port,
                             input mem_bus_pkg::mem_req_t cmd);
        if (port == mem_bus_pkg::PORT_A) begin
            i_cmd_a = cmd;
            i_req_a = 1'b1;
        end else begin
            i_cmd_b = cmd;
            i_req_b = 1'b1;
        end
    endtask

    task automatic drop_req(input mem_bus_pkg::port_sel_t port);
        if (port == mem_bus_pkg::PORT_A) i_req_a = 1'b0;
        else i_req_b = 1'b0;
    endtask

    // Polls ack on falling edges until it reaches level
    task automatic wait_ack(input mem_bus_pkg::port_sel_t port, input logic level,
                            output bit ok);
        int n;
        n = 0;
        while (ack_of(port) != level && n < ACK_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        waited = n;
        ok     = (ack_of(port) == level);
        if (!ok) begin
            $display("timeout in %s: port %s ack did not go %0d within %0d cycles",
                     test_name, port_name(port), level, ACK_TIMEOUT);
            errors++;
        end
    endtask

    task automatic check_word(input mem_cfg_pkg::word_t exp, input mem_cfg_pkg::word_t act);
        checks++;
        if (act !== exp) begin
            $display("error %s: expected %h, actual %h", test_name, exp, act);
            errors++;
        end
    endtask

    // One full four-phase cycle, model updated on a completed write
    task automatic do_access(input mem_bus_pkg::port_sel_t port,
                             input mem_bus_pkg::mem_req_t cmd,
                             output mem_cfg_pkg::word_t rdata_out);
        bit ok;
        rdata_out = '0;
        @(negedge clk);
        raise_req(port, cmd);
        wait_ack(port, 1'b1, ok);
        last_lat = waited - 1;    // First edge only samples req
        if (ok) rdata_out = rdata_of(port);
        drop_req(port);
        wait_ack(port, 1'b0, ok);
        if (ok && cmd.write) ref_mem[cmd.addr] = cmd.wdata;
    endtask

    task automatic apply_reset();
        @(negedge clk);
        i_rst   = 1'b1;
        i_req_a = 1'b0;
        i_req_b = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        i_rst = 1'b0;
        for (int i = 0; i < mem_cfg_pkg::MEM_DEPTH; i++) begin
            ref_mem[i] = '0;    // RAM clears on reset
        end
    endtask

    task automatic end_test(input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, errors - errs_before);
        end
    endtask

    task automatic test_reset_clear();
        mem_cfg_pkg::addr_t addrs [4];
        mem_cfg_pkg::word_t rd;
        int e0;
        e0        = errors;
        test_name = "reset_clear";
        addrs     = '{10'd0, 10'd1, 10'd511, 10'd1023};
        // Nonzero words first, the reset must wipe them
        foreach (addrs[i]) begin
            do_access(mem_bus_pkg::PORT_A,
                      make_cmd(addrs[i], 32'ha5a5_0000 | 32'(addrs[i]), 1'b1), rd);
        end
        apply_reset();
        foreach (addrs[i]) begin
            do_access(mem_bus_pkg::PORT_A, make_cmd(addrs[i], '0, 1'b0), rd);
            check_word('0, rd);
            check_word(32'd2, mem_cfg_pkg::word_t'(last_lat));    // Idle latency
        end
        end_test(e0);
    endtask

    task automatic test_write_read();
        mem_cfg_pkg::word_t rd;
        int e0;
        e0        = errors;
        test_name = "write_read";
        do_access(mem_bus_pkg::PORT_A, make_cmd(10'h055, 32'hdead_beef, 1'b1), rd);
        check_word(32'hdead_beef, rd);    // Write returns stored word
        do_access(mem_bus_pkg::PORT_A, make_cmd(10'h055, '0, 1'b0), rd);
        check_word(ref_mem[10'h055], rd);
        end_test(e0);
    endtask

    task automatic test_cross_port();
        mem_cfg_pkg::word_t rd;
        int e0;
        e0        = errors;
        test_name = "cross_port";
        do_access(mem_bus_pkg::PORT_A, make_cmd(10'h100, 32'h1234_5678, 1'b1), rd);
        do_access(mem_bus_pkg::PORT_B, make_cmd(10'h100, '0, 1'b0), rd);
        check_word(32'h1234_5678, rd);
        do_access(mem_bus_pkg::PORT_B, make_cmd(10'h101, 32'h9abc_def0, 1'b1), rd);
        do_access(mem_bus_pkg::PORT_A, make_cmd(10'h101, '0, 1'b0), rd);
        check_word(32'h9abc_def0, rd);
        end_test(e0);
    endtask

    // Both ports write one address in the same cycle
    task automatic test_contention();
        mem_cfg_pkg::word_t rd;
        bit ok;
        int e0;
        e0        = errors;
        test_name = "contention";
        apply_reset();    // Last served back to B, so A must win
        @(negedge clk);
        raise_req(mem_bus_pkg::PORT_A, make_cmd(10'h2a0, 32'haaaa_0001, 1'b1));
        raise_req(mem_bus_pkg::PORT_B, make_cmd(10'h2a0, 32'hbbbb_0002, 1'b1));
        wait_ack(mem_bus_pkg::PORT_A, 1'b1, ok);
        if (ok) begin
            if (o_ack_b) begin
                $display("port B acked together with port A in %s", test_name);
                errors++;
            end
            check_word(32'haaaa_0001, o_rdata_a);
            ref_mem[10'h2a0] = 32'haaaa_0001;
        end
        drop_req(mem_bus_pkg::PORT_A);
        wait_ack(mem_bus_pkg::PORT_B, 1'b1, ok);
        if (ok) begin
            check_word(32'hbbbb_0002, o_rdata_b);
            ref_mem[10'h2a0] = 32'hbbbb_0002;
        end
        drop_req(mem_bus_pkg::PORT_B);
        wait_ack(mem_bus_pkg::PORT_B, 1'b0, ok);
        do_access(mem_bus_pkg::PORT_A, make_cmd(10'h2a0, '0, 1'b0), rd);
        check_word(32'hbbbb_0002, rd);    // B wrote last
        end_test(e0);
    endtask

    // A holds its ack while B waits
    task automatic test_back_pressure();
        bit ok;
        int e0;
        e0        = errors;
        test_name = "back_pressure";
        @(negedge clk);
        raise_req(mem_bus_pkg::PORT_A, make_cmd(10'h3c3, 32'h5a5a_c3c3, 1'b1));
        wait_ack(mem_bus_pkg::PORT_A, 1'b1, ok);
        if (ok) ref_mem[10'h3c3] = 32'h5a5a_c3c3;
        raise_req(mem_bus_pkg::PORT_B, make_cmd(10'h3c3, '0, 1'b0));
        repeat (10) begin
            @(negedge clk);
            if (o_ack_b) begin
                $display("port B acked while port A still held its request in %s",
                         test_name);
                errors++;
            end
        end
        drop_req(mem_bus_pkg::PORT_A);
        wait_ack(mem_bus_pkg::PORT_A, 1'b0, ok);
        wait_ack(mem_bus_pkg::PORT_B, 1'b1, ok);
        if (ok) check_word(ref_mem[10'h3c3], o_rdata_b);
        drop_req(mem_bus_pkg::PORT_B);
        wait_ack(mem_bus_pkg::PORT_B, 1'b0, ok);
        end_test(e0);
    endtask

    task automatic test_random_traffic();
        logic [31:0]             r;
        mem_bus_pkg::port_sel_t  port;
        mem_cfg_pkg::addr_t      addr;
        mem_cfg_pkg::word_t      data;
        mem_cfg_pkg::word_t      exp;
        mem_cfg_pkg::word_t      rd;
        logic                    write;
        int e0;
        e0        = errors;
        test_name = "random_traffic";
        repeat (40) begin
            r     = $random(seed);
            data  = $random(seed);
            port  = mem_bus_pkg::port_sel_t'(r[0]);
            write = r[1];
            addr  = {6'b100000, r[5:2]};    // 16 words, so reads hit earlier writes
            exp   = write ? data : ref_mem[addr];
            do_access(port, make_cmd(addr, data, write), rd);
            check_word(exp, rd);
        end
        end_test(e0);
    endtask

    initial begin
        seed         = 32'h04f7_3e5b;
        i_rst        = 1'b1;
        i_req_a      = 1'b0;
        i_req_b      = 1'b0;
        i_cmd_a      = '0;
        i_cmd_b      = '0;
        checks       = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_name    = "init";

        apply_reset();
        test_reset_clear();
        test_write_read();
        test_cross_port();
        test_contention();
        test_back_pressure();
        test_random_traffic();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
